// File: synth.f
verilog/synth_pkg.sv
verilog/cfg_input.sv
verilog/frame_sequencer.sv
verilog/oscillator_bank.sv
verilog/svf_filter.sv
verilog/pwm_output.sv
verilog/synth_top.sv
sim/synth_tb.sv

// File: Makefile
# Verilator build for the synth core

VERILATOR ?= verilator
FLIST     ?= synth.f
TB_TOP    ?= synth_tb
RTL_TOP   ?= synth_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/synth_tb.sv
`timescale 1ns/100ps

module synth_tb;

	import synth_pkg::*;

	logic       clk;
	logic       reset;
	logic [7:0] cfg_data;
	logic [1:0] cfg_addr;
	logic       cfg_hi;
	logic       cfg_strobe;
	logic [OUT_BITS-1:0] sample_out;
	logic       pwm;

	integer seed = 69;
	integer rnd;
	logic   checking = 1'b0;
	logic   sat_phase = 1'b0;
	logic   hit_extreme = 1'b0;

	// Model state
	logic [4:0]         m_step;
	logic [16:0]        m_div;
	logic [14:0]        m_lfsr;
	logic [9:0]         m_cnt [2];
	logic [1:0]         m_wave [2];
	logic signed [19:0] m_y;
	logic signed [19:0] m_v;
	logic [4:0]         m_pwm;
	logic [15:0]        m_regs [4];
	logic               m_s1;
	logic               m_s2;
	logic               m_prev;

	synth_top dut (
		.clk, .reset, .cfg_data, .cfg_addr, .cfg_hi, .cfg_strobe, .sample_out, .pwm
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Cycle model
	// ========================================
	function automatic logic signed [19:0] sat_add(logic signed [19:0] a, logic signed [19:0] b);
		logic signed [19:0] s;
		s = a + b;
		if (!a[19] && !b[19] && s[19])
			s = 20'h7FFFF;
		else if (a[19] && b[19] && !s[19])
			s = 20'h80000;
		return s;
	endfunction

	function automatic logic [3:0] oct_shift(logic [3:0] oct);
		return (oct == 4'd15) ? 4'd15 : oct + 4'd1;
	endfunction

	task automatic advance_model();
		logic        idx;
		logic [1:0]  wf;
		logic [1:0]  w;
		logic [2:0]  ws;
		logic [17:0] en;
		logic [16:0] dith;
		logic [3:0]  oct;
		logic        enb;
		logic        fire;
		logic signed [16:0] src;
		logic signed [19:0] ext;
		logic signed [19:0] sum;
		logic [3:0]  samt;
		logic        to_y;
		logic        to_v;
		logic        add_v;
		logic        fe;
		logic        write;
		if (reset) begin
			m_step = 0;
			m_div = 0;
			m_lfsr = '1;
			m_cnt = '{default: 0};
			m_wave = '{default: 0};
			m_y = 0;
			m_v = 0;
			m_pwm = 0;
			m_regs = '{default: 16'hFFFF}; // Register file resets to all ones
			m_s1 = 0;
			m_s2 = 0;
			m_prev = 0;
		end else begin
			fe = (m_step == 5'd31);
			en = {(m_div + 17'd1) & ~m_div, 1'b1};
			for (int k = 0; k < 15; k++)
				dith[k] = m_div[14-k];
			dith[16:15] = {2{dith[14]}}; // Sign extension of the reversed count

			// Wave sample of oscillator step[0] before its update
			idx = m_step[0];
			wf = m_regs[3][2*idx +: 2];
			w = m_wave[idx];
			case (wf)
				2'd1:    ws = {~w[1], 2'b10};
				2'd0:    ws = {w != 2'b11, 2'b11};
				default: ws = {~w[1], w[0], 1'b1};
			endcase

			if (m_step < 5'd2) begin
				oct = m_regs[idx][12:9];
				enb = (oct != 4'd15) && en[oct];
				fire = enb && (m_cnt[idx][9:2] == 0);
				if (enb)
					m_cnt[idx] = m_cnt[idx] + (fire ? {1'b1, m_regs[idx][8:0]} : 10'd0) - 10'd4;
				if (fire)
					m_wave[idx] = (wf == 2'd2) ? {~m_lfsr[1], m_lfsr[0]} : m_wave[idx] + 2'd1;
			end

			// Filter step
			to_y = 0;
			to_v = 0;
			add_v = 0;
			src = 0;
			samt = 0;
			case (m_step)
				5'd0, 5'd1: begin
					add_v = m_regs[3][6+idx];
					to_v = add_v;
					to_y = !add_v;
					src = {ws, 14'd0};
					samt = oct_shift(m_regs[2][11:8]);
				end
				5'd2: begin
					to_v = 1;
					add_v = 1;
					src = ~m_v[19:3];
					samt = oct_shift(m_regs[2][7:4]);
				end
				5'd3: begin
					to_y = 1;
					src = m_v[19:3];
					samt = oct_shift(m_regs[2][3:0]);
				end
				5'd4: begin
					to_v = 1;
					add_v = 1;
					src = ~m_y[19:3];
					samt = oct_shift(m_regs[2][3:0]);
				end
				5'd31: src = dith;
				default: ;
			endcase
			ext = src;
			sum = sat_add(add_v ? m_v : m_y, ext >>> samt);
			if (to_y)
				m_y = sum;
			if (to_v)
				m_v = sum;

			if (fe)
				m_pwm = {~sum[19], sum[18:15]};
			else if (m_pwm != 0)
				m_pwm = m_pwm - 5'd1;

			if (fe) begin
				m_div = m_div + 17'd1;
				m_lfsr = {m_lfsr[13:0], m_lfsr[0] ^ m_lfsr[14]};
			end

			// Strobe synchronizer
			// Write lands after this cycle's reads
			write = m_s2 && !m_prev;
			if (write) begin
				if (cfg_hi)
					m_regs[cfg_addr][15:8] = cfg_data;
				else
					m_regs[cfg_addr][7:0] = cfg_data;
			end
			m_prev = m_s2;
			m_s2 = m_s1;
			m_s1 = cfg_strobe;
			m_step = m_step + 5'd1;
		end
	endtask

	always @(posedge clk)
		advance_model();

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_sample(logic [OUT_BITS-1:0] got, logic [OUT_BITS-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: sample_out = %h, expected %h", $time, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_pwm(logic got, logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: pwm = %b, expected %b", $time, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	always @(negedge clk) begin
		if (checking) begin
			check_sample(sample_out, {~m_y[19], m_y[18:12]});
			check_pwm(pwm, m_pwm != 0);
			if (sat_phase && (sample_out == 8'h00 || sample_out == 8'hFF))
				hit_extreme <= 1'b1;
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	task automatic wait_frame_end();
		int n;
		for (n = 0; n < 40; n++) begin
			@(negedge clk);
			if (m_step == 5'd31)
				break;
		end
		if (n == 40) begin
			$display("No frame boundary seen within 40 cycles");
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic run_frames(int frames);
		for (int f = 0; f < frames; f++)
			wait_frame_end();
	endtask

	task automatic write_byte(logic [1:0] addr, logic hi, logic [7:0] data);
		@(posedge clk);
		cfg_addr <= addr;
		cfg_hi <= hi;
		cfg_data <= data;
		@(posedge clk);
		cfg_strobe <= 1'b1;
		repeat (4) @(posedge clk);
		cfg_strobe <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	// Low octave 0 to 2 and a random mantissa
	task automatic write_osc(logic [1:0] addr, logic [3:0] max_oct);
		logic [8:0] mant;
		logic [3:0] oct;
		rnd = $random(seed);
		mant = rnd[8:0];
		oct = (rnd[11:10] > max_oct[1:0]) ? max_oct : {2'b00, rnd[11:10]};
		write_byte(addr, 1'b0, mant[7:0]);
		write_byte(addr, 1'b1, {3'b000, oct, mant[8]});
	endtask

	initial begin
		reset = 1'b1;
		cfg_data = 8'h00;
		cfg_addr = 2'd0;
		cfg_hi = 1'b0;
		cfg_strobe = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		checking <= 1'b1;

		// Reset state and idle register file
		for (int c = 0; c < 32; c++) begin
			@(negedge clk);
			if (c == 0)
				check_sample(sample_out, 8'h80);
			check_pwm(pwm, 1'b0);
		end
		run_frames(200);

		// Saw then noise on oscillator 0
		write_osc(2'd0, 4'd2);
		rnd = $random(seed);
		write_byte(2'd2, 1'b0, {2'b01, rnd[1:0], 2'b01, rnd[3:2]});
		write_byte(2'd2, 1'b1, {6'd1, rnd[5:4]});
		write_byte(2'd3, 1'b0, {rnd[7:6], 2'b00, 2'b11, 2'b11});
		run_frames(150);
		write_byte(2'd3, 1'b0, {rnd[7:6], 2'b00, 2'b11, 2'b10});
		run_frames(150);

		// Pulse and square mixed
		write_osc(2'd1, 4'd2);
		rnd = $random(seed);
		write_byte(2'd3, 1'b0, {rnd[1:0], 2'b00, 2'b01, 2'b00});
		run_frames(200);
		write_byte(2'd3, 1'b0, {rnd[3:2], 2'b00, 2'b00, 2'b01});
		run_frames(100);

		// Low octaves drive the filter into saturation
		write_osc(2'd0, 4'd0);
		write_osc(2'd1, 4'd0);
		write_byte(2'd2, 1'b0, 8'h11);
		write_byte(2'd2, 1'b1, 8'h00);
		write_byte(2'd3, 1'b0, 8'h05); // Square on both into y
		sat_phase = 1'b1;
		for (int f = 0; f < 3000 && !hit_extreme; f++)
			wait_frame_end();
		if (!hit_extreme) begin
			$display("sample_out never reached 0x00 or 0xFF with saturating filter settings");
			$display("Simulation FAILED");
			$fatal(1);
		end
		sat_phase = 1'b0;

		// Random byte writes during a running tone
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			write_byte(rnd[1:0], rnd[2], rnd[10:3]);
			run_frames(10);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog/synth_top.sv
`timescale 1ns/100ps

module synth_top #(
	parameter int OCT_BITS        = 4,
	parameter int OSC_PERIOD_BITS = 10,
	parameter int WAVE_BITS       = 2,
	parameter int LEAST_SHR       = 3,
	parameter int DIVIDER_BITS    = 17
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [7:0]                          cfg_data,
	input  logic [synth_pkg::CFG_ADDR_BITS-1:0] cfg_addr,
	input  logic                                cfg_hi,
	input  logic                                cfg_strobe, // Asynchronous
	output logic [synth_pkg::OUT_BITS-1:0]      sample_out,
	output logic                                pwm
);

	import synth_pkg::*;

	localparam int FSTATE_BITS  = WAVE_BITS + LEAST_SHR + 2**OCT_BITS - 1;
	localparam int SHIFTER_BITS = WAVE_BITS + 2**OCT_BITS - 1;

	logic [OSC_PERIOD_BITS-2:0]     osc_mantissa [NUM_OSCS];
	logic [OCT_BITS-1:0]            osc_oct [NUM_OSCS];
	waveform_e                      osc_waveform [NUM_OSCS];
	logic [OCT_BITS-1:0]            cutoff_oct;
	logic [OCT_BITS-1:0]            damp_oct;
	logic [OCT_BITS-1:0]            vol_oct;
	logic [NUM_OSCS-1:0]            yv_sel;
	filter_step_e                   step;
	logic                           frame_end;
	logic [DIVIDER_BITS:0]          oct_enables;
	logic [WAVE_BITS-1:0]           noise;
	logic signed [SHIFTER_BITS-1:0] dither;
	logic [WAVE_BITS:0]             wave_sample;
	logic signed [FSTATE_BITS-1:0]  y;
	logic [FSTATE_BITS-1:0]         filter_sum;

	// ========================================
	// Input side
	// ========================================
	cfg_input #(.OCT_BITS(OCT_BITS), .OSC_PERIOD_BITS(OSC_PERIOD_BITS)) u_cfg_input (
		.clk, .reset, .cfg_data, .cfg_addr, .cfg_hi, .cfg_strobe,
		.osc_mantissa, .osc_oct, .cutoff_oct, .damp_oct, .vol_oct, .osc_waveform, .yv_sel
	);

	frame_sequencer #(.OCT_BITS(OCT_BITS), .WAVE_BITS(WAVE_BITS), .LEAST_SHR(LEAST_SHR),
		.DIVIDER_BITS(DIVIDER_BITS)) u_frame_sequencer (
		.clk, .reset, .step, .frame_end, .oct_enables, .noise, .dither
	);

	// ========================================
	// Processing
	// ========================================
	oscillator_bank #(.OCT_BITS(OCT_BITS), .OSC_PERIOD_BITS(OSC_PERIOD_BITS),
		.WAVE_BITS(WAVE_BITS), .DIVIDER_BITS(DIVIDER_BITS)) u_oscillator_bank (
		.clk, .reset, .step, .oct_enables, .noise, .osc_mantissa, .osc_oct, .osc_waveform,
		.wave_sample
	);

	svf_filter #(.OCT_BITS(OCT_BITS), .WAVE_BITS(WAVE_BITS), .LEAST_SHR(LEAST_SHR)) u_svf_filter (
		.clk, .reset, .step, .wave_sample, .yv_sel, .cutoff_oct, .damp_oct, .vol_oct, .dither,
		.y, .filter_sum
	);

	// Output side
	pwm_output #(.OCT_BITS(OCT_BITS), .WAVE_BITS(WAVE_BITS), .LEAST_SHR(LEAST_SHR)) u_pwm_output (
		.clk, .reset, .frame_end, .filter_sum, .y, .pwm, .sample_out
	);

endmodule

// File: verilog/pwm_output.sv
`timescale 1ns/100ps

module pwm_output #(
	parameter int OCT_BITS     = 4,
	parameter int WAVE_BITS    = 2,
	parameter int LEAST_SHR    = 3,
	localparam int FSTATE_BITS = WAVE_BITS + LEAST_SHR + 2**OCT_BITS - 1
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            frame_end,
	input  logic [FSTATE_BITS-1:0]          filter_sum,
	input  logic signed [FSTATE_BITS-1:0]   y,
	output logic                            pwm,
	output logic [synth_pkg::OUT_BITS-1:0]  sample_out
);

	import synth_pkg::*;

	logic [STEP_BITS-1:0] pwm_counter;

	assign pwm = pwm_counter != '0;

	// Load once per frame with dither already added by the filter adder
	always_ff @(posedge clk) begin
		if (reset)
			pwm_counter <= '0;
		else if (frame_end)
			pwm_counter <= {~filter_sum[FSTATE_BITS-1], filter_sum[FSTATE_BITS-2 -: STEP_BITS-1]};
		else if (pwm)
			pwm_counter <= pwm_counter - 1'b1;
	end

	// Offset binary copy of the y state
	assign sample_out = {~y[FSTATE_BITS-1], y[FSTATE_BITS-2 -: OUT_BITS-1]};

endmodule

// File: verilog/svf_filter.sv
`timescale 1ns/100ps

module svf_filter #(
	parameter int OCT_BITS      = 4,
	parameter int WAVE_BITS     = 2,
	parameter int LEAST_SHR     = 3,
	localparam int FEED_SHL     = 2**OCT_BITS - 1,
	localparam int FSTATE_BITS  = WAVE_BITS + LEAST_SHR + FEED_SHL,
	localparam int SHIFTER_BITS = WAVE_BITS + FEED_SHL
) (
	input  logic                           clk,
	input  logic                           reset,
	input  synth_pkg::filter_step_e        step,
	input  logic [WAVE_BITS:0]             wave_sample,
	input  logic [synth_pkg::NUM_OSCS-1:0] yv_sel,
	input  logic [OCT_BITS-1:0]            cutoff_oct,
	input  logic [OCT_BITS-1:0]            damp_oct,
	input  logic [OCT_BITS-1:0]            vol_oct,
	input  logic signed [SHIFTER_BITS-1:0] dither,
	output logic signed [FSTATE_BITS-1:0]  y,
	output logic [FSTATE_BITS-1:0]         filter_sum
);

	import synth_pkg::*;

	localparam int IDX_BITS = $clog2(NUM_OSCS);

	typedef enum logic [1:0] {
		TARGET_Y,
		TARGET_V,
		TARGET_NONE
	} target_e;

	logic [STEP_BITS-1:0]          step_bits;
	logic [IDX_BITS-1:0]           osc_idx;
	target_e                       target;
	logic                          a_sel_v;   // Addend is v rather than y
	logic signed [SHIFTER_BITS-1:0] shifter_src;
	logic [OCT_BITS-1:0]           shift_oct;
	logic                          shift_zero;
	logic [OCT_BITS:0]             shift_inc;
	logic [OCT_BITS-1:0]           shift_amt;
	logic signed [FSTATE_BITS-1:0] v;
	logic signed [FSTATE_BITS-1:0] a_src;
	logic signed [FSTATE_BITS-1:0] src_ext;
	logic signed [FSTATE_BITS-1:0] b_src;
	logic [FSTATE_BITS-1:0]        raw_sum;
	logic                          sat_max;
	logic                          sat_min;

	assign step_bits = step;
	assign osc_idx   = step_bits[IDX_BITS-1:0];

	// ========================================
	// Step decoder
	// ========================================
	always_comb begin
		target      = TARGET_NONE;
		a_sel_v     = 1'b0;
		shifter_src = '0;
		shift_oct   = '0;
		shift_zero  = 1'b0;
		case (step)
			STEP_VOL0, STEP_VOL1: begin
				target      = yv_sel[osc_idx] ? TARGET_V : TARGET_Y;
				a_sel_v     = yv_sel[osc_idx];
				shifter_src = {wave_sample, {(FEED_SHL-1){1'b0}}}; // Centered feed
				shift_oct   = vol_oct;
			end
			STEP_DAMP: begin
				target      = TARGET_V;
				a_sel_v     = 1'b1;
				shifter_src = ~v[FSTATE_BITS-1:LEAST_SHR]; // Inversion as cheap negate
				shift_oct   = damp_oct;
			end
			STEP_CUTOFF_Y: begin
				target      = TARGET_Y;
				shifter_src = v[FSTATE_BITS-1:LEAST_SHR];
				shift_oct   = cutoff_oct;
			end
			STEP_CUTOFF_V: begin
				target      = TARGET_V;
				a_sel_v     = 1'b1;
				shifter_src = ~y[FSTATE_BITS-1:LEAST_SHR];
				shift_oct   = cutoff_oct;
			end
			STEP_OUTPUT: begin
				shifter_src = dither; // Sum feeds the PWM, states untouched
				shift_zero  = 1'b1;
			end
			default: target = TARGET_NONE;
		endcase
	end

	// ========================================
	// Shifter and saturating adder
	// ========================================
	assign shift_inc = {1'b0, shift_oct} + 1'b1;
	assign shift_amt = shift_zero ? '0 : (shift_inc[OCT_BITS] ? '1 : shift_inc[OCT_BITS-1:0]);

	assign src_ext = FSTATE_BITS'(shifter_src);
	assign b_src   = src_ext >>> shift_amt;
	assign a_src   = a_sel_v ? v : y;
	assign raw_sum = a_src + b_src;

	assign sat_max = ~a_src[FSTATE_BITS-1] & ~b_src[FSTATE_BITS-1] & raw_sum[FSTATE_BITS-1];
	assign sat_min = a_src[FSTATE_BITS-1] & b_src[FSTATE_BITS-1] & ~raw_sum[FSTATE_BITS-1];

	always_comb begin
		if (sat_max)
			filter_sum = {1'b0, {(FSTATE_BITS-1){1'b1}}};
		else if (sat_min)
			filter_sum = {1'b1, {(FSTATE_BITS-1){1'b0}}};
		else
			filter_sum = raw_sum;
	end

	// Filter states
	always_ff @(posedge clk) begin
		if (reset) begin
			y <= '0;
			v <= '0;
		end else begin
			if (target == TARGET_Y)
				y <= filter_sum;
			if (target == TARGET_V)
				v <= filter_sum;
		end
	end

endmodule

// File: verilog/oscillator_bank.sv
`timescale 1ns/100ps

module oscillator_bank #(
	parameter int OCT_BITS        = 4,
	parameter int OSC_PERIOD_BITS = 10,
	parameter int WAVE_BITS       = 2,
	parameter int DIVIDER_BITS    = 17
) (
	input  logic                        clk,
	input  logic                        reset,
	input  synth_pkg::filter_step_e     step,
	input  logic [DIVIDER_BITS:0]       oct_enables,
	input  logic [WAVE_BITS-1:0]        noise,
	input  logic [OSC_PERIOD_BITS-2:0]  osc_mantissa [synth_pkg::NUM_OSCS],
	input  logic [OCT_BITS-1:0]         osc_oct [synth_pkg::NUM_OSCS],
	input  synth_pkg::waveform_e        osc_waveform [synth_pkg::NUM_OSCS],
	output logic [WAVE_BITS:0]          wave_sample
);

	import synth_pkg::*;

	localparam int IDX_BITS  = $clog2(NUM_OSCS);
	localparam int OCT_STEPS = 2**OCT_BITS;

	logic [STEP_BITS-1:0]       step_bits;
	logic [IDX_BITS-1:0]        idx;
	logic                       update;
	logic [OCT_STEPS-1:0]       oct_gate;
	logic [OCT_BITS-1:0]        cur_oct;
	logic                       enable;
	logic                       fire;
	logic [OSC_PERIOD_BITS-1:0] period;
	logic [OSC_PERIOD_BITS-1:0] counter_next;
	logic [WAVE_BITS-1:0]       cur_wave;
	logic [WAVE_BITS-1:0]       wave_next;
	waveform_e                  cur_wf;

	logic [OSC_PERIOD_BITS-1:0] counter [NUM_OSCS];
	logic [WAVE_BITS-1:0]       wave [NUM_OSCS];

	assign step_bits = step;
	assign idx       = step_bits[IDX_BITS-1:0]; // Oscillator served this step
	assign update    = step_bits < STEP_BITS'(NUM_OSCS);

	// ========================================
	// Shared counter datapath
	// ========================================
	assign oct_gate = {1'b0, oct_enables[OCT_STEPS-2:0]}; // Top octave never runs
	assign cur_oct  = osc_oct[idx];
	assign enable   = oct_gate[cur_oct];
	assign fire     = enable & ~|counter[idx][OSC_PERIOD_BITS-1:WAVE_BITS];
	assign period   = {1'b1, osc_mantissa[idx]};

	assign counter_next = counter[idx] + (fire ? period : '0)
		- OSC_PERIOD_BITS'(1 << WAVE_BITS);

	// Wave register update
	assign cur_wave  = wave[idx];
	assign cur_wf    = osc_waveform[idx];
	assign wave_next = (cur_wf == WF_NOISE) ? {~noise[WAVE_BITS-1], noise[WAVE_BITS-2:0]}
		: cur_wave + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_OSCS; i++) begin
				counter[i] <= '0;
				wave[i]    <= '0;
			end
		end else if (update) begin
			if (enable)
				counter[idx] <= counter_next;
			if (fire)
				wave[idx] <= wave_next;
		end
	end

	// ========================================
	// Waveform shaping
	// ========================================
	always_comb begin
		case (cur_wf)
			WF_SQUARE: wave_sample = {~cur_wave[WAVE_BITS-1], 2'b10};
			WF_PULSE:  wave_sample = {cur_wave[WAVE_BITS-1 -: 2] != 2'b11, 2'b11}; // Quarter duty
			default:   wave_sample = {~cur_wave[WAVE_BITS-1], cur_wave[WAVE_BITS-2:0], 1'b1};
		endcase
	end

endmodule

// File: verilog/frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer #(
	parameter int OCT_BITS      = 4,
	parameter int WAVE_BITS     = 2,
	parameter int LEAST_SHR     = 3,
	parameter int DIVIDER_BITS  = 17,
	localparam int SHIFTER_BITS = WAVE_BITS + 2**OCT_BITS - 1
) (
	input  logic                           clk,
	input  logic                           reset,
	output synth_pkg::filter_step_e        step,
	output logic                           frame_end,
	output logic [DIVIDER_BITS:0]          oct_enables,
	output logic [WAVE_BITS-1:0]           noise,
	output logic signed [SHIFTER_BITS-1:0] dither
);

	import synth_pkg::*;

	localparam int DITHER_BITS = SHIFTER_BITS - (STEP_BITS - LEAST_SHR);

	logic [STEP_BITS-1:0]    step_cnt;
	logic [DIVIDER_BITS-1:0] divider;
	logic [DIVIDER_BITS-1:0] divider_next;
	logic [LFSR_BITS-1:0]    lfsr;

	assign step         = filter_step_e'(step_cnt);
	assign frame_end    = &step_cnt;
	assign divider_next = divider + 1'b1;
	assign oct_enables  = {divider_next & ~divider, 1'b1}; // Rising divider bits

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
			divider  <= '0;
			lfsr     <= '1;
		end else begin
			step_cnt <= step_cnt + 1'b1; // Wraps at the end of the frame
			if (frame_end) begin
				divider <= divider_next;
				lfsr    <= {lfsr[LFSR_BITS-2:0], lfsr[0] ^ lfsr[LFSR_BITS-1]};
			end
		end
	end

	assign noise = lfsr[WAVE_BITS-1:0];

	// Dither is the divider count bit reversed, so the fastest bit weighs most
	// Sign bit of the reversed count is divider bit 0
	assign dither[SHIFTER_BITS-1:DITHER_BITS] = {(SHIFTER_BITS-DITHER_BITS){divider[0]}};
	for (genvar i = 0; i < DITHER_BITS; i++) begin : g_dither
		assign dither[i] = divider[DITHER_BITS-1-i];
	end

endmodule

// File: verilog/cfg_input.sv
`timescale 1ns/100ps

module cfg_input #(
	parameter int OCT_BITS        = 4,
	parameter int OSC_PERIOD_BITS = 10
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [7:0]                             cfg_data,
	input  logic [synth_pkg::CFG_ADDR_BITS-1:0]    cfg_addr,
	input  logic                                   cfg_hi,
	input  logic                                   cfg_strobe,
	output logic [OSC_PERIOD_BITS-2:0]             osc_mantissa [synth_pkg::NUM_OSCS],
	output logic [OCT_BITS-1:0]                    osc_oct [synth_pkg::NUM_OSCS],
	output logic [OCT_BITS-1:0]                    cutoff_oct,
	output logic [OCT_BITS-1:0]                    damp_oct,
	output logic [OCT_BITS-1:0]                    vol_oct,
	output synth_pkg::waveform_e                   osc_waveform [synth_pkg::NUM_OSCS],
	output logic [synth_pkg::NUM_OSCS-1:0]         yv_sel
);

	import synth_pkg::*;

	localparam int WF_BITS = $bits(waveform_e);
	localparam int OSC_WORD [NUM_OSCS] = '{CFG_OSC0, CFG_OSC1};

	logic [1:0]  strobe_sync; // Two flop synchronizer
	logic        strobe_q;
	logic        strobe_prev;
	logic        cfg_write;
	logic [15:0] cfg_regs [CFG_WORDS];

	// ========================================
	// Strobe synchronizer and edge detect
	// ========================================
	assign strobe_q  = strobe_sync[1];
	assign cfg_write = strobe_q & ~strobe_prev; // Rising edge only

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_sync <= '0;
			strobe_prev <= 1'b0;
		end else begin
			strobe_sync <= {strobe_sync[0], cfg_strobe};
			strobe_prev <= strobe_q;
		end
	end

	// ========================================
	// Register file
	// ========================================
	// All ones at reset parks both oscillators at octave 15
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < CFG_WORDS; w++)
				cfg_regs[w] <= '1;
		end else if (cfg_write) begin
			if (cfg_hi)
				cfg_regs[cfg_addr][15:8] <= cfg_data;
			else
				cfg_regs[cfg_addr][7:0] <= cfg_data;
		end
	end

	// Field decode
	for (genvar i = 0; i < NUM_OSCS; i++) begin : g_osc_fields
		assign osc_mantissa[i] = cfg_regs[OSC_WORD[i]][OSC_PERIOD_BITS-2:0];
		assign osc_oct[i]      = cfg_regs[OSC_WORD[i]][OSC_PERIOD_BITS-2+OCT_BITS -: OCT_BITS];
		assign osc_waveform[i] = waveform_e'(cfg_regs[CFG_MISC][WF_BITS*i +: WF_BITS]);
	end

	assign cutoff_oct = cfg_regs[CFG_FILTER][OCT_BITS-1:0];
	assign damp_oct   = cfg_regs[CFG_FILTER][2*OCT_BITS-1 -: OCT_BITS];
	assign vol_oct    = cfg_regs[CFG_FILTER][3*OCT_BITS-1 -: OCT_BITS];
	assign yv_sel     = cfg_regs[CFG_MISC][7 -: NUM_OSCS]; // 1 feeds v, 0 feeds y

endmodule

// File: verilog/synth_pkg.sv
package synth_pkg;

	// ========================================
	// Frame timing
	// ========================================
	localparam int STEP_BITS = 5; // 32 cycles per sample frame
	localparam int NUM_OSCS  = 2;

	// ========================================
	// Configuration word map
	// ========================================
	localparam int CFG_WORDS     = 4;
	localparam int CFG_ADDR_BITS = 2;
	localparam int CFG_OSC0      = 0; // Mantissa 8:0, octave 12:9
	localparam int CFG_OSC1      = 1;
	localparam int CFG_FILTER    = 2; // Cutoff 3:0, damp 7:4, volume 11:8
	localparam int CFG_MISC      = 3; // Waveforms 3:0, y/v select 7:6

	localparam int OUT_BITS  = 8;
	localparam int LFSR_BITS = 15;

	typedef enum logic [1:0] {
		WF_PULSE  = 2'd0,
		WF_SQUARE = 2'd1,
		WF_NOISE  = 2'd2,
		WF_SAW    = 2'd3
	} waveform_e;

	// Steps of the sample frame that do filter work
	// VOL0 and VOL1 differ only in bit 0, which picks the oscillator
	typedef enum logic [STEP_BITS-1:0] {
		STEP_VOL0     = STEP_BITS'(0),
		STEP_VOL1     = STEP_BITS'(1),
		STEP_DAMP     = STEP_BITS'(2),
		STEP_CUTOFF_Y = STEP_BITS'(3),
		STEP_CUTOFF_V = STEP_BITS'(4),
		STEP_OUTPUT   = {STEP_BITS{1'b1}}
	} filter_step_e;

endpackage
